/* hdl/huff_consts.svh */
`ifndef HUFF_CONSTS_SVH
`define HUFF_CONSTS_SVH

// character code width
`define CHAR_W 7

// one histogram entry per character code
`define NUM_CHARS 128

// per-character occurrence counter width
`define CNT_W 16

`define EOF_CHAR 7'h1A

`endif

/* hdl/huff_data_pkg.sv */
`include "huff_consts.svh"

package huff_data_pkg;

  // a 7-bit character as it arrives on the intake
  typedef logic [`CHAR_W-1:0] char_t;

  // occurrence count of a single character
  // saturates at all ones in the histogram
  typedef logic [`CNT_W-1:0] count_t;

  // accepted characters over a whole run
  // wraps rather than saturating
  typedef logic [31:0] total_t;

endpackage

/* hdl/huff_ctrl_pkg.sv */
package huff_ctrl_pkg;

  // run controller states
  // clear and count are entered once per start strobe
  typedef enum logic [2:0] {
    RUN_IDLE   = 3'd0,
    RUN_CLEAR  = 3'd1,
    RUN_COUNT  = 3'd2,
    RUN_SEARCH = 3'd3,
    RUN_REPORT = 3'd4
  } run_state_e;

  // number of valid least-value slots after a scan
  // 0 = none, 1 = only least1, 2 = both
  typedef logic [1:0] found_t;

endpackage

/* hdl/huff_run_ctrl.sv */
`timescale 1ns/1ps
`include "huff_consts.svh"

module huff_run_ctrl (
  input  logic                 hwclk_i,
  input  logic                 arst_n_i,
  input  logic                 start_i,
  input  logic                 char_valid_i,
  input  huff_data_pkg::char_t char_i,
  input  logic                 scan_done_i,
  output logic                 hist_clear_o,
  output logic                 count_en_o,
  output logic                 scan_start_o,
  output logic                 ready_o,
  output logic                 done_o
);
  import huff_ctrl_pkg::*;

  run_state_e state_q;
  run_state_e state_d;
  logic       eof_accepted;
  logic       scan_start_q;

  // EOF only ends the count phase when the intake is open
  assign eof_accepted = (state_q == RUN_COUNT) && char_valid_i && (char_i == `EOF_CHAR);

  always_comb begin
    state_d = state_q;
    case (state_q)
      RUN_IDLE: begin
        if (start_i) begin
          state_d = RUN_CLEAR;
        end
      end
      // single cycle, histogram is wiped here
      RUN_CLEAR: begin
        state_d = RUN_COUNT;
      end
      RUN_COUNT: begin
        if (eof_accepted) begin
          state_d = RUN_SEARCH;
        end
      end
      RUN_SEARCH: begin
        if (scan_done_i) begin
          state_d = RUN_REPORT;
        end
      end
      RUN_REPORT: begin
        state_d = RUN_IDLE;
      end
      default: begin
        state_d = RUN_IDLE;
      end
    endcase
  end

  always_ff @(posedge hwclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= RUN_IDLE;
      scan_start_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      // high in the first search cycle only
      scan_start_q <= eof_accepted;
    end
  end

  assign hist_clear_o = (state_q == RUN_CLEAR);
  assign ready_o      = (state_q == RUN_COUNT);
  assign count_en_o   = ready_o;
  assign scan_start_o = scan_start_q;
  assign done_o       = (state_q == RUN_REPORT);

  // encoding has spare codes 5..7 that must never be reached
  a_state_legal: assert property (
    @(posedge hwclk_i) disable iff (!arst_n_i)
    state_q inside {RUN_IDLE, RUN_CLEAR, RUN_COUNT, RUN_SEARCH, RUN_REPORT}
  );

endmodule

/* hdl/huff_histogram.sv */
`timescale 1ns/1ps
`include "huff_consts.svh"

module huff_histogram (
  input  logic                  hwclk_i,
  input  logic                  arst_n_i,
  input  logic                  clear_i,
  input  logic                  inc_i,
  input  huff_data_pkg::char_t  inc_char_i,
  input  huff_data_pkg::char_t  rd_addr_i,
  output huff_data_pkg::count_t rd_count_o,
  output huff_data_pkg::total_t total_o
);
  import huff_data_pkg::*;

  count_t cnt_q [`NUM_CHARS];
  total_t total_q;
  logic   cnt_full;

  // addressed entry already at its ceiling
  assign cnt_full = (cnt_q[inc_char_i] == '1);

  // per-character counters
  always_ff @(posedge hwclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `NUM_CHARS; i++) begin
        cnt_q[i] <= '0;
      end
    end else if (clear_i) begin
      for (int i = 0; i < `NUM_CHARS; i++) begin
        cnt_q[i] <= '0;
      end
    end else if (inc_i && !cnt_full) begin
      cnt_q[inc_char_i] <= cnt_q[inc_char_i] + 1'b1;
    end
  end

  // running total, keeps counting past a saturated entry
  always_ff @(posedge hwclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      total_q <= '0;
    end else if (clear_i) begin
      total_q <= '0;
    end else if (inc_i) begin
      total_q <= total_q + 1'b1;
    end
  end

  // combinational read for the finder scan
  assign rd_count_o = cnt_q[rd_addr_i];
  assign total_o    = total_q;

  // clear comes from the controller's clear state, increments only while counting
  a_no_clear_and_inc: assert property (
    @(posedge hwclk_i) disable iff (!arst_n_i)
    !(clear_i && inc_i)
  );

endmodule

/* hdl/huff_least_finder.sv */
`timescale 1ns/1ps
`include "huff_consts.svh"

module huff_least_finder (
  input  logic                  hwclk_i,
  input  logic                  arst_n_i,
  input  logic                  start_i,
  input  huff_data_pkg::count_t rd_count_i,
  output huff_data_pkg::char_t  rd_addr_o,
  output logic                  done_o,
  output huff_data_pkg::char_t  least1_char_o,
  output huff_data_pkg::char_t  least2_char_o,
  output huff_data_pkg::count_t least1_count_o,
  output huff_data_pkg::count_t least2_count_o,
  output huff_ctrl_pkg::found_t found_o
);
  import huff_data_pkg::*;
  import huff_ctrl_pkg::*;

  char_t  addr_q;
  logic   busy_q;
  logic   done_q;
  logic   last_addr;
  char_t  l1_char_q;
  char_t  l2_char_q;
  count_t l1_count_q;
  count_t l2_count_q;
  found_t found_q;

  assign last_addr = (addr_q == `CHAR_W'(`NUM_CHARS - 1));

  always_ff @(posedge hwclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      addr_q     <= '0;
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      l1_char_q  <= '0;
      l2_char_q  <= '0;
      l1_count_q <= '0;
      l2_count_q <= '0;
      found_q    <= '0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        // fresh scan, old results dropped
        addr_q     <= '0;
        busy_q     <= 1'b1;
        l1_char_q  <= '0;
        l2_char_q  <= '0;
        l1_count_q <= '0;
        l2_count_q <= '0;
        found_q    <= '0;
      end else if (busy_q) begin
        // zero counts never take part
        if (rd_count_i != '0) begin
          if (found_q == 2'd0) begin
            l1_char_q  <= addr_q;
            l1_count_q <= rd_count_i;
            found_q    <= 2'd1;
          end else if (rd_count_i < l1_count_q) begin
            // new minimum, old least1 moves down
            l2_char_q  <= l1_char_q;
            l2_count_q <= l1_count_q;
            l1_char_q  <= addr_q;
            l1_count_q <= rd_count_i;
            found_q    <= 2'd2;
          end else if (found_q == 2'd1) begin
            l2_char_q  <= addr_q;
            l2_count_q <= rd_count_i;
            found_q    <= 2'd2;
          end else if (rd_count_i < l2_count_q) begin
            l2_char_q  <= addr_q;
            l2_count_q <= rd_count_i;
          end
        end
        if (last_addr) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end else begin
          addr_q <= addr_q + 1'b1;
        end
      end
    end
  end

  assign rd_addr_o      = addr_q;
  assign done_o         = done_q;
  assign least1_char_o  = l1_char_q;
  assign least2_char_o  = l2_char_q;
  assign least1_count_o = l1_count_q;
  assign least2_count_o = l2_count_q;
  assign found_o        = found_q;

  // ordering must survive all 128 updates of the scan
  a_least_ordered: assert property (
    @(posedge hwclk_i) disable iff (!arst_n_i)
    (done_q && (found_q == 2'd2)) |-> (l1_count_q <= l2_count_q)
  );

endmodule

/* hdl/huff_front_top.sv */
`timescale 1ns/1ps
`include "huff_consts.svh"

module huff_front_top (
  input  logic                  hwclk_i,
  input  logic                  arst_n_i,
  input  logic                  start_i,
  input  logic                  char_valid_i,
  input  huff_data_pkg::char_t  char_i,
  output logic                  ready_o,
  output logic                  done_o,
  output huff_data_pkg::total_t total_o,
  output huff_data_pkg::char_t  least1_char_o,
  output huff_data_pkg::count_t least1_count_o,
  output huff_data_pkg::char_t  least2_char_o,
  output huff_data_pkg::count_t least2_count_o,
  output huff_ctrl_pkg::found_t found_o
);
  import huff_data_pkg::*;

  logic   hist_clear;
  logic   count_en;
  logic   scan_start;
  logic   scan_done;
  logic   hist_inc;
  char_t  rd_addr;
  count_t rd_count;

  // EOF closes the run but is never counted
  assign hist_inc = char_valid_i && count_en && (char_i != `EOF_CHAR);

  huff_run_ctrl u_huff_run_ctrl (
    .hwclk_i      (hwclk_i),
    .arst_n_i     (arst_n_i),
    .start_i      (start_i),
    .char_valid_i (char_valid_i),
    .char_i       (char_i),
    .scan_done_i  (scan_done),
    .hist_clear_o (hist_clear),
    .count_en_o   (count_en),
    .scan_start_o (scan_start),
    .ready_o      (ready_o),
    .done_o       (done_o)
  );

  huff_histogram u_huff_histogram (
    .hwclk_i    (hwclk_i),
    .arst_n_i   (arst_n_i),
    .clear_i    (hist_clear),
    .inc_i      (hist_inc),
    .inc_char_i (char_i),
    .rd_addr_i  (rd_addr),
    .rd_count_o (rd_count),
    .total_o    (total_o)
  );

  huff_least_finder u_huff_least_finder (
    .hwclk_i        (hwclk_i),
    .arst_n_i       (arst_n_i),
    .start_i        (scan_start),
    .rd_count_i     (rd_count),
    .rd_addr_o      (rd_addr),
    .done_o         (scan_done),
    .least1_char_o  (least1_char_o),
    .least2_char_o  (least2_char_o),
    .least1_count_o (least1_count_o),
    .least2_count_o (least2_count_o),
    .found_o        (found_o)
  );

endmodule

/* bench/huff_front_checks.svh */
`ifndef HUFF_FRONT_CHECKS_SVH
`define HUFF_FRONT_CHECKS_SVH

task automatic report_mismatch(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
  $display("[ERROR] %s %s: expected 0x%0h actual 0x%0h", test_name, what, exp, act);
  fail_run("value mismatch");
endtask

task automatic check_flag(input string what, input logic exp, input logic act);
  if (act !== exp) begin
    report_mismatch(what, 32'(exp), 32'(act));
  end
endtask

task automatic check_char(input string what, input char_t exp, input char_t act);
  if (act !== exp) begin
    report_mismatch(what, 32'(exp), 32'(act));
  end
endtask

task automatic check_count(input string what, input count_t exp, input count_t act);
  if (act !== exp) begin
    report_mismatch(what, 32'(exp), 32'(act));
  end
endtask

task automatic check_total(input string what, input total_t exp, input total_t act);
  if (act !== exp) begin
    report_mismatch(what, exp, act);
  end
endtask

task automatic check_found(input string what, input found_t exp, input found_t act);
  if (act !== exp) begin
    report_mismatch(what, 32'(exp), 32'(act));
  end
endtask

// one-cycle start strobe
task automatic pulse_start();
  @(posedge hwclk);
  start <= 1'b1;
  @(posedge hwclk);
  start <= 1'b0;
endtask

// outputs are looked at on the falling edge
task automatic wait_ready();
  do begin
    @(negedge hwclk);
  end while (!ready);
endtask

task automatic wait_done();
  do begin
    @(negedge hwclk);
  end while (!done);
endtask

// back-to-back calls give a pulse every cycle
task automatic send_char(input char_t c);
  @(posedge hwclk);
  char_valid <= 1'b1;
  char_code  <= c;
endtask

task automatic idle_cycle();
  @(posedge hwclk);
  char_valid <= 1'b0;
endtask

// full run over stream_q, EOF appended here
task automatic run_stream(input bit with_gaps);
  clear_model();
  foreach (stream_q[i]) begin
    ref_cnt[stream_q[i]] = ref_cnt[stream_q[i]] + 1;
  end
  pulse_start();
  wait_ready();
  foreach (stream_q[i]) begin
    // about one idle cycle in eight
    if (with_gaps && ($urandom_range(0, 7) == 0)) begin
      idle_cycle();
    end
    send_char(stream_q[i]);
  end
  send_char(`EOF_CHAR);
  idle_cycle();
  wait_done();
  compute_expected();
endtask

`endif

/* bench/huff_front_tb.sv */
`timescale 1ns/1ps
`include "huff_consts.svh"

module huff_front_tb;
  import huff_data_pkg::*;
  import huff_ctrl_pkg::*;

  // nine runs, the longest near 600 cycles, sit far below this limit
  localparam int TIMEOUT_CYCLES = 20000;

  logic   hwclk;
  logic   arst_n;
  logic   start;
  logic   char_valid;
  char_t  char_code;
  logic   ready;
  logic   done;
  total_t total;
  char_t  least1_char;
  count_t least1_count;
  char_t  least2_char;
  count_t least2_count;
  found_t found;

  // reference model
  int     ref_cnt [`NUM_CHARS];
  char_t  stream_q [$];
  string  test_name;
  int     cycle_cnt = 0;
  total_t exp_total;
  found_t exp_found;
  char_t  exp_l1_char;
  count_t exp_l1_count;
  char_t  exp_l2_char;
  count_t exp_l2_count;

  huff_front_top u_huff_front_top (
    .hwclk_i        (hwclk),
    .arst_n_i       (arst_n),
    .start_i        (start),
    .char_valid_i   (char_valid),
    .char_i         (char_code),
    .ready_o        (ready),
    .done_o         (done),
    .total_o        (total),
    .least1_char_o  (least1_char),
    .least1_count_o (least1_count),
    .least2_char_o  (least2_char),
    .least2_count_o (least2_count),
    .found_o        (found)
  );

  initial begin
    hwclk = 1'b0;
    forever #2 hwclk = ~hwclk;
  end

  always @(posedge hwclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the DUT never finished a run", cycle_cnt);
      fail_run("timeout");
    end
  end

  task automatic fail_run(input string reason);
    $display("RESULT: FAIL");
    $fatal(1, "%s", reason);
  endtask

  `include "huff_front_checks.svh"

  task automatic clear_model();
    for (int i = 0; i < `NUM_CHARS; i++) begin
      ref_cnt[i] = 0;
    end
  endtask

  task automatic load_string(input string s);
    stream_q.delete();
    for (int i = 0; i < s.len(); i++) begin
      stream_q.push_back(char_t'(s[i]));
    end
  endtask

  // results ordered by count, then by character code
  task automatic compute_expected();
    int best1;
    int best2;
    best1 = -1;
    best2 = -1;
    exp_total = '0;
    for (int i = 0; i < `NUM_CHARS; i++) begin
      exp_total = exp_total + total_t'(ref_cnt[i]);
      if (ref_cnt[i] != 0 && (best1 < 0 || ref_cnt[i] < ref_cnt[best1])) begin
        best1 = i;
      end
    end
    for (int i = 0; i < `NUM_CHARS; i++) begin
      if (i != best1 && ref_cnt[i] != 0 && (best2 < 0 || ref_cnt[i] < ref_cnt[best2])) begin
        best2 = i;
      end
    end
    exp_found    = (best2 >= 0) ? 2'd2 : (best1 >= 0) ? 2'd1 : 2'd0;
    exp_l1_char  = (best1 >= 0) ? char_t'(best1) : '0;
    exp_l1_count = (best1 >= 0) ? count_t'(ref_cnt[best1]) : '0;
    exp_l2_char  = (best2 >= 0) ? char_t'(best2) : '0;
    exp_l2_count = (best2 >= 0) ? count_t'(ref_cnt[best2]) : '0;
  endtask

  task automatic check_results();
    check_total("total", exp_total, total);
    check_found("found", exp_found, found);
    check_char("least1 char", exp_l1_char, least1_char);
    check_count("least1 count", exp_l1_count, least1_count);
    check_char("least2 char", exp_l2_char, least2_char);
    check_count("least2 count", exp_l2_count, least2_count);
  endtask

  task automatic test_reset_and_start();
    test_name = "reset_and_start";
    clear_model();
    compute_expected();
    @(negedge hwclk);
    check_flag("ready", 1'b0, ready);
    check_flag("done", 1'b0, done);
    check_results();
    pulse_start();
    // clear state after the first edge, intake open after the second
    @(negedge hwclk);
    check_flag("ready one edge after start", 1'b0, ready);
    @(negedge hwclk);
    check_flag("ready two edges after start", 1'b1, ready);
    send_char(`EOF_CHAR);
    idle_cycle();
    wait_done();
    check_results();
  endtask

  task automatic test_basic_stream();
    test_name = "basic_aab";
    load_string("aab");
    run_stream(1'b0);
    check_results();
    check_char("least1 is b", 7'h62, least1_char);
  endtask

  task automatic test_ties_and_empty();
    test_name = "tie_cdcd";
    load_string("cdcd");
    run_stream(1'b0);
    check_results();
    check_char("lower code wins", 7'h63, least1_char);
    test_name = "single_char";
    load_string("eee");
    run_stream(1'b0);
    check_results();
    test_name = "immediate_eof";
    stream_q.delete();
    run_stream(1'b0);
    check_results();
  endtask

  task automatic test_dropped_pulses();
    test_name = "dropped_pulses";
    // intake closed in idle
    send_char(7'h71);
    send_char(7'h72);
    idle_cycle();
    @(negedge hwclk);
    check_results();
    load_string("hello");
    run_stream(1'b0);
    check_results();
    send_char(7'h6F);
    send_char(`EOF_CHAR);
    send_char(7'h6F);
    idle_cycle();
    repeat (4) @(negedge hwclk);
    check_results();
  endtask

  task automatic test_random_stream();
    char_t c;
    test_name = "random_stream";
    stream_q.delete();
    repeat (300) begin
      do begin
        c = char_t'($urandom_range(0, `NUM_CHARS - 1));
      end while (c == `EOF_CHAR);
      stream_q.push_back(c);
    end
    run_stream(1'b1);
    check_results();
  endtask

  task automatic test_back_to_back();
    test_name = "back_to_back_first";
    load_string("zzzq");
    run_stream(1'b0);
    check_results();
    test_name = "back_to_back_second";
    load_string("mmn");
    run_stream(1'b0);
    check_results();
    check_total("total after clear", 32'd3, total);
  endtask

  initial begin
    void'($urandom(57469));
    arst_n     <= 1'b0;
    start      <= 1'b0;
    char_valid <= 1'b0;
    char_code  <= '0;
    repeat (5) @(posedge hwclk);
    arst_n <= 1'b1;
    test_reset_and_start();
    test_basic_stream();
    test_ties_and_empty();
    test_dropped_pulses();
    test_random_stream();
    test_back_to_back();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* huff_front_top.f */
+incdir+hdl
+incdir+bench
hdl/huff_data_pkg.sv
hdl/huff_ctrl_pkg.sv
hdl/huff_run_ctrl.sv
hdl/huff_histogram.sv
hdl/huff_least_finder.sv
hdl/huff_front_top.sv
bench/huff_front_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -j 0 \
  --top-module huff_front_tb \
  -f huff_front_top.f

./obj_dir/Vhuff_front_tb | tee "$LOG"

if grep -qx "RESULT: PASS" "$LOG"; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
